// ==== mc_subsystem.f ====
+incdir+include
source/mc_pkg.sv
source/mc_tag_programmer.sv
source/mc_io_host.sv
source/mc_request_router.sv
source/mc_tile.sv
source/mc_subsystem.sv
verif/mc_subsystem_tb.sv

// ==== Makefile ====
# Verilator flow for mc_subsystem, run from the project root

TB_TOP = mc_subsystem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f mc_subsystem.f \
	  --top-module mc_subsystem

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f mc_subsystem.f \
	  --top-module $(TB_TOP) -Mdir obj_dir -o mc_sim
	./obj_dir/mc_sim | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verif/mc_subsystem_trace.txt ====
# columns: test op x y addr(hex) data(hex) kind
# op is ld, st or rst; kind is none, load or stat; ld data is the expected value
reset_clear  ld  0 0 00 00000000 load
reset_clear  ld  1 0 3a 00000000 load
reset_clear  ld  0 1 7f 00000000 load
reset_clear  ld  1 1 c4 00000000 load
reset_clear  ld  1 1 fe 00000000 load
store_load   st  0 0 10 deadbeef none
store_load   ld  0 0 10 deadbeef load
store_load   ld  1 0 10 00000000 load
store_load   ld  0 1 10 00000000 load
store_load   ld  1 1 10 00000000 load
store_load   st  1 1 10 12345678 none
store_load   ld  1 1 10 12345678 load
store_load   ld  0 0 10 deadbeef load
pipeline     st  0 0 40 00000a00 none
pipeline     st  1 0 40 00000a10 none
pipeline     st  0 1 40 00000a01 none
pipeline     st  1 1 40 00000a11 none
pipeline     ld  0 0 40 00000a00 load
pipeline     ld  1 0 40 00000a10 load
pipeline     ld  0 1 40 00000a01 load
pipeline     ld  1 1 40 00000a11 load
pipeline     ld  0 0 10 deadbeef load
print_stat   st  1 0 ff cafef00d stat
print_stat   ld  1 0 ff 00000000 load
print_stat   st  0 1 ff 00000007 stat
print_stat   ld  0 1 40 00000a01 load
mid_reset    st  0 0 20 aaaa5555 none
mid_reset    ld  0 0 20 aaaa5555 load
mid_reset    rst 0 0 00 00000000 none
mid_reset    ld  0 0 20 00000000 load
mid_reset    ld  1 1 10 00000000 load
mid_reset    ld  1 0 40 00000000 load
mid_reset    ld  0 1 ff 00000000 load

// ==== verif/mc_subsystem_tb.sv ====
`include "mc_consts.svh"

module mc_subsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_tiles_lp    = `MC_TILES_X * `MC_TILES_Y;
  localparam int tile_bits_lp    = $clog2(num_tiles_lp);
  localparam int reset_cycles_lp = 10;
  localparam int ready_min_lp    = `MC_DMEM_WORDS + `MC_RESET_DEPTH;
  localparam int ready_limit_lp  = 2 * `MC_DMEM_WORDS;
  localparam int drain_limit_lp  = 64;
  // 4 cycles through the DUT, one more for the NBA drive
  localparam int due_offset_lp   = 5;

  typedef struct packed {
    logic          stat;
    mc_pkg::data_t data;
    logic [31:0]   due;
  } expect_s;

  logic            clk = 1'b0;
  logic            rst;
  logic            req_v;
  mc_pkg::mc_op_e  req_op;
  mc_pkg::x_cord_t req_x;
  mc_pkg::y_cord_t req_y;
  mc_pkg::addr_t   req_addr;
  mc_pkg::data_t   req_data;
  logic            ready;
  logic            resp_v;
  mc_pkg::data_t   resp_data;
  logic            stat_v;
  mc_pkg::data_t   stat_tag;
  logic [31:0]     cycle;

  mc_pkg::data_t   model_mem [num_tiles_lp][`MC_DMEM_WORDS];
  expect_s         exp_q [$];
  logic [31:0]     edge_cnt = '0;
  logic [31:0]     ready_edge;
  int              err_cnt;
  int              test_cnt;
  int              test_fail_cnt;

  mc_subsystem dut_i (
    .clk_i            (clk),
    .rst_i            (rst),
    .req_v_i          (req_v),
    .req_op_i         (req_op),
    .req_x_i          (req_x),
    .req_y_i          (req_y),
    .req_addr_i       (req_addr),
    .req_data_i       (req_data),
    .ready_o          (ready),
    .resp_v_o         (resp_v),
    .resp_data_o      (resp_data),
    .print_stat_v_o   (stat_v),
    .print_stat_tag_o (stat_tag),
    .cycle_o          (cycle)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 32'd1;
  end

  task automatic check_response(input expect_s e);
    mc_pkg::data_t got;
    got = e.stat ? stat_tag : resp_data;
    assert (stat_v == e.stat) else begin
      $display("FAIL %0t print_stat_v_o expected %0b got %0b", $time, e.stat, stat_v);
      err_cnt++;
    end
    assert (got == e.data) else begin
      $display("FAIL %0t %s expected %h got %h", $time,
               e.stat ? "print_stat_tag_o" : "resp_data_o", e.data, got);
      err_cnt++;
    end
    assert (edge_cnt == e.due) else begin
      $display("FAIL %0t response edge expected %0d got %0d", $time, e.due, edge_cnt);
      err_cnt++;
    end
    assert (cycle == edge_cnt - ready_edge) else begin
      $display("FAIL %0t cycle_o expected %0d got %0d", $time, edge_cnt - ready_edge, cycle);
      err_cnt++;
    end
  endtask

  task automatic watch_responses();
    expect_s e;
    forever begin
      @(posedge clk);
      if (resp_v || stat_v) begin
        if (exp_q.size() == 0) begin
          $display("unexpected response at %0t with nothing outstanding", $time);
          err_cnt++;
        end else begin
          e = exp_q.pop_front();
          check_response(e);
        end
      end else if (exp_q.size() != 0 && exp_q[0].due < edge_cnt) begin
        $display("no response at %0t for the request due at edge %0d", $time, exp_q[0].due);
        e = exp_q.pop_front();
        err_cnt++;
      end
    end
  endtask

  task automatic issue(input mc_pkg::mc_op_e op, input int x, input int y,
                       input mc_pkg::addr_t addr, input mc_pkg::data_t data,
                       input logic want_ret, input logic stat, input mc_pkg::data_t exp_data);
    expect_s e;
    @(posedge clk);
    req_v    <= 1'b1;
    req_op   <= op;
    req_x    <= mc_pkg::x_cord_t'(x);
    req_y    <= mc_pkg::y_cord_t'(y);
    req_addr <= addr;
    req_data <= data;
    if (want_ret) begin
      e.stat = stat;
      e.data = exp_data;
      e.due  = edge_cnt + 32'(due_offset_lp);
      exp_q.push_back(e);
    end
  endtask

  // idle the inputs, then wait out every outstanding return
  task automatic drain(output bit ok);
    int n;
    @(posedge clk);
    req_v <= 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < drain_limit_lp) begin
      @(posedge clk);
      n++;
    end
    ok = (exp_q.size() == 0);
    if (!ok) begin
      $display("timeout: %0d responses still outstanding after %0d cycles", exp_q.size(), n);
      err_cnt++;
    end
  endtask

  task automatic wait_ready(output bit ok);
    int n;
    n = 0;
    while (!ready && n < ready_limit_lp) begin
      @(posedge clk);
      n++;
    end
    ok = (ready == 1'b1);
    if (!ok) begin
      $display("timeout: ready_o still low %0d cycles after reset", n);
      err_cnt++;
    end else begin
      ready_edge = edge_cnt; // cycle_o counts from here
      assert (n >= ready_min_lp) else begin
        $display("ready_o rose after %0d cycles, before clearing and reset delay were done", n);
        err_cnt++;
      end
    end
  endtask

  task automatic apply_reset(output bit ok);
    @(posedge clk);
    rst <= 1'b1;
    repeat (reset_cycles_lp) @(posedge clk);
    assert (ready == 1'b0) else begin
      $display("FAIL %0t ready_o expected 0 got %0b", $time, ready);
      err_cnt++;
    end
    rst <= 1'b0;
    model_mem = '{default: '0}; // sweep zeroes every tile
    wait_ready(ok);
  endtask

  task automatic close_test(input string name, input int err_base, output bit ok);
    drain(ok);
    test_cnt++;
    if (err_cnt == err_base) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s failed with %0d errors", name, err_cnt - err_base);
      test_fail_cnt++;
    end
  endtask

  task automatic run_trace(output bit ok);
    int                       fd;
    int                       line_no;
    int                       n;
    int                       x_val;
    int                       y_val;
    int                       err_base;
    logic [tile_bits_lp-1:0]  tile;
    logic [31:0]              addr_val;
    logic [31:0]              data_val;
    logic                     is_stat;
    mc_pkg::addr_t            addr;
    mc_pkg::data_t            exp_data;
    mc_pkg::mc_op_e           op;
    string                    line;
    string                    name_tok;
    string                    op_tok;
    string                    kind_tok;
    string                    want_kind;
    string                    cur_name;
    ok       = 1'b1;
    cur_name = "";
    err_base = err_cnt;
    line_no  = 0;
    fd = $fopen("verif/mc_subsystem_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open verif/mc_subsystem_trace.txt");
      err_cnt++;
      ok = 1'b0;
    end else begin
      while ($fgets(line, fd) != 0) begin
        line_no++;
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %s %d %d %h %h %s", name_tok, op_tok, x_val, y_val,
                    addr_val, data_val, kind_tok);
        if (n != 7) begin
          $display("trace line %0d is malformed", line_no);
          err_cnt++;
          continue;
        end
        if (name_tok != cur_name) begin
          if (cur_name != "") begin
            close_test(cur_name, err_base, ok);
            if (!ok) break;
          end
          cur_name = name_tok;
          err_base = err_cnt;
        end
        if (op_tok == "rst") begin
          drain(ok);
          if (ok) apply_reset(ok);
          if (!ok) break;
        end else if (op_tok == "ld" || op_tok == "st") begin
          tile    = tile_bits_lp'(y_val * `MC_TILES_X + x_val);
          addr    = mc_pkg::addr_t'(addr_val);
          is_stat = (op_tok == "st") && (addr_val == `MC_PRINT_STAT_ADDR);
          if (op_tok == "ld") begin
            op        = mc_pkg::OP_LOAD;
            want_kind = "load";
            exp_data  = model_mem[tile][addr];
            assert (data_val == exp_data) else begin
              $display("FAIL %0t trace data on line %0d expected %h got %h", $time,
                       line_no, exp_data, data_val);
              err_cnt++;
            end
          end else begin
            op        = mc_pkg::OP_STORE;
            want_kind = is_stat ? "stat" : "none";
            exp_data  = data_val; // stat tag is the store data
            if (!is_stat) model_mem[tile][addr] = data_val;
          end
          assert (kind_tok == want_kind) else begin
            $display("trace line %0d gives kind %s where %s is due", line_no, kind_tok, want_kind);
            err_cnt++;
          end
          issue(op, x_val, y_val, addr, data_val, want_kind != "none", is_stat, exp_data);
        end else begin
          $display("trace line %0d has unknown op %s", line_no, op_tok);
          err_cnt++;
        end
      end
      if (ok && cur_name != "") begin
        close_test(cur_name, err_base, ok);
      end
      $fclose(fd);
    end
  endtask

  task automatic finish_run();
    $display("%0d tests, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  initial begin : main
    bit ok;
    rst           = 1'b1;
    req_v         = 1'b0;
    req_op        = mc_pkg::OP_LOAD;
    req_x         = '0;
    req_y         = '0;
    req_addr      = '0;
    req_data      = '0;
    ready_edge    = '0;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    fork
      watch_responses();
    join_none
    apply_reset(ok);
    if (ok) begin
      run_trace(ok);
    end
    if (ok) begin
      repeat (8) @(posedge clk); // stray returns show up here
    end
    finish_run();
  end

endmodule

// ==== source/mc_subsystem.sv ====
`include "mc_consts.svh"

module mc_subsystem (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            req_v_i,
  input  mc_pkg::mc_op_e  req_op_i,
  input  mc_pkg::x_cord_t req_x_i,
  input  mc_pkg::y_cord_t req_y_i,
  input  mc_pkg::addr_t   req_addr_i,
  input  mc_pkg::data_t   req_data_i,
  output logic            ready_o,
  output logic            resp_v_o,
  output mc_pkg::data_t   resp_data_o,
  output logic            print_stat_v_o,
  output mc_pkg::data_t   print_stat_tag_o,
  output logic [31:0]     cycle_o
);

  logic            clear_v;
  mc_pkg::addr_t   clear_addr;
  logic            core_rst;
  mc_pkg::mc_req_s host_req;
  mc_pkg::mc_ret_s host_ret;
  mc_pkg::mc_req_s tile_req [`MC_TILES_X*`MC_TILES_Y];
  mc_pkg::mc_ret_s tile_ret [`MC_TILES_X*`MC_TILES_Y];

  mc_tag_programmer tag_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .clear_v_o    (clear_v),
    .clear_addr_o (clear_addr),
    .core_rst_o   (core_rst)
  );

  mc_io_host io_i (
    .clk_i            (clk_i),
    .rst_i            (core_rst),
    .req_v_i          (req_v_i),
    .req_op_i         (req_op_i),
    .req_x_i          (req_x_i),
    .req_y_i          (req_y_i),
    .req_addr_i       (req_addr_i),
    .req_data_i       (req_data_i),
    .ret_i            (host_ret),
    .req_o            (host_req),
    .ready_o          (ready_o),
    .resp_v_o         (resp_v_o),
    .resp_data_o      (resp_data_o),
    .print_stat_v_o   (print_stat_v_o),
    .print_stat_tag_o (print_stat_tag_o),
    .cycle_o          (cycle_o)
  );

  mc_request_router router_i (
    .clk_i      (clk_i),
    .rst_i      (core_rst),
    .req_i      (host_req),
    .tile_req_o (tile_req),
    .tile_ret_i (tile_ret),
    .ret_o      (host_ret)
  );

  // row major, matches router decode
  for (genvar y = 0; y < `MC_TILES_Y; y++) begin : g_y
    for (genvar x = 0; x < `MC_TILES_X; x++) begin : g_x
      mc_tile tile_i (
        .clk_i        (clk_i),
        .rst_i        (core_rst),
        .req_i        (tile_req[y*`MC_TILES_X+x]),
        .clear_v_i    (clear_v),
        .clear_addr_i (clear_addr),
        .ret_o        (tile_ret[y*`MC_TILES_X+x])
      );
    end
  end

endmodule

// ==== source/mc_tile.sv ====
`include "mc_consts.svh"

module mc_tile (
  input  logic            clk_i,
  input  logic            rst_i,
  input  mc_pkg::mc_req_s req_i,
  input  logic            clear_v_i,
  input  mc_pkg::addr_t   clear_addr_i,
  output mc_pkg::mc_ret_s ret_o
);

  localparam mc_pkg::addr_t stat_addr_lp = mc_pkg::addr_t'(`MC_PRINT_STAT_ADDR);

  mc_pkg::data_t   mem [`MC_DMEM_WORDS];
  mc_pkg::mc_ret_s ret_n;
  logic            is_load;
  logic            is_stat;
  logic            is_write;

  assign is_load  = req_i.v && (req_i.op == mc_pkg::OP_LOAD);
  assign is_stat  = req_i.v && (req_i.op == mc_pkg::OP_STORE) && (req_i.addr == stat_addr_lp);
  assign is_write = req_i.v && (req_i.op == mc_pkg::OP_STORE) && (req_i.addr != stat_addr_lp);

  // data memory
  always_ff @(posedge clk_i) begin
    if (clear_v_i) begin
      mem[clear_addr_i] <= '0;
    end else if (is_write) begin
      mem[req_i.addr] <= req_i.data;
    end
  end

  always_comb begin
    ret_n.v    = is_load || is_stat;
    ret_n.kind = is_load ? mc_pkg::RET_LOAD : mc_pkg::RET_STAT;
    ret_n.data = is_load ? mem[req_i.addr] : req_i.data; // stat carries store data
  end

  always_ff @(posedge clk_i) begin
    ret_o <= ret_n;
    if (rst_i) begin
      ret_o.v <= 1'b0;
    end
  end

  // sweep only runs while cores are held in reset
  a_clear_no_req: assert property (@(posedge clk_i) !(clear_v_i && req_i.v))
    else $error("clear and request in the same cycle");

endmodule

// ==== source/mc_request_router.sv ====
`include "mc_consts.svh"

module mc_request_router (
  input  logic            clk_i,
  input  logic            rst_i,
  input  mc_pkg::mc_req_s req_i,
  output mc_pkg::mc_req_s tile_req_o [`MC_TILES_X*`MC_TILES_Y],
  input  mc_pkg::mc_ret_s tile_ret_i [`MC_TILES_X*`MC_TILES_Y],
  output mc_pkg::mc_ret_s ret_o
);

  localparam int num_tiles_lp  = `MC_TILES_X * `MC_TILES_Y;
  localparam int idx_width_lp  = $clog2(num_tiles_lp);

  logic [idx_width_lp-1:0] dest_idx;
  logic [num_tiles_lp-1:0] ret_v;
  mc_pkg::mc_ret_s         ret_merged;

  // row major tile index
  assign dest_idx = idx_width_lp'(req_i.y) * idx_width_lp'(`MC_TILES_X)
                  + idx_width_lp'(req_i.x);

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < num_tiles_lp; i++) begin
      tile_req_o[i]   <= req_i;
      tile_req_o[i].v <= req_i.v && (dest_idx == idx_width_lp'(i));
      if (rst_i) begin
        tile_req_o[i].v <= 1'b0;
      end
    end
  end

  // one return at most per cycle, so OR is enough
  always_comb begin
    ret_merged = '0;
    for (int i = 0; i < num_tiles_lp; i++) begin
      if (tile_ret_i[i].v) begin
        ret_merged = ret_merged | tile_ret_i[i]; // idle tiles still drive kind and data
      end
      ret_v[i]   = tile_ret_i[i].v;
    end
  end

  always_ff @(posedge clk_i) begin
    ret_o <= ret_merged;
    if (rst_i) begin
      ret_o.v <= 1'b0;
    end
  end

  // fixed latency everywhere keeps returns apart
  a_one_return: assert property (@(posedge clk_i) disable iff (rst_i) $countones(ret_v) <= 1)
    else $error("more than one tile return valid");

endmodule

// ==== source/mc_io_host.sv ====
module mc_io_host (
  input  logic            clk_i,
  input  logic            rst_i,

  input  logic            req_v_i,
  input  mc_pkg::mc_op_e  req_op_i,
  input  mc_pkg::x_cord_t req_x_i,
  input  mc_pkg::y_cord_t req_y_i,
  input  mc_pkg::addr_t   req_addr_i,
  input  mc_pkg::data_t   req_data_i,

  input  mc_pkg::mc_ret_s ret_i,
  output mc_pkg::mc_req_s req_o,

  output logic            ready_o,
  output logic            resp_v_o,
  output mc_pkg::data_t   resp_data_o,
  output logic            print_stat_v_o,
  output mc_pkg::data_t   print_stat_tag_o,
  output logic [31:0]     cycle_o
);

  mc_pkg::mc_req_s req_n;

  always_comb begin
    req_n.v    = req_v_i;
    req_n.op   = req_op_i;
    req_n.x    = req_x_i;
    req_n.y    = req_y_i;
    req_n.addr = req_addr_i;
    req_n.data = req_data_i;
  end

  // outgoing packet; only valid is cleared in reset
  always_ff @(posedge clk_i) begin
    req_o <= req_n;
    if (rst_i) begin
      req_o.v <= 1'b0; // drops strobes while held
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_o <= 1'b0;
      cycle_o <= '0;
    end else begin
      ready_o <= 1'b1;
      // zero on the edge ready rises
      cycle_o <= ready_o ? cycle_o + 32'd1 : '0;
    end
  end

  // return decode by kind
  assign resp_v_o         = ret_i.v && (ret_i.kind == mc_pkg::RET_LOAD);
  assign resp_data_o      = ret_i.data;
  assign print_stat_v_o   = ret_i.v && (ret_i.kind == mc_pkg::RET_STAT);
  assign print_stat_tag_o = ret_i.data;

  a_req_when_ready: assert property (@(posedge clk_i) !ready_o |-> !req_v_i)
    else $error("req_v_i high while ready_o low");

endmodule

// ==== source/mc_tag_programmer.sv ====
`include "mc_consts.svh"

module mc_tag_programmer (
  input  logic          clk_i,
  input  logic          rst_i,
  output logic          clear_v_o,
  output mc_pkg::addr_t clear_addr_o,
  output logic          core_rst_o
);

  localparam mc_pkg::addr_t last_addr_lp = mc_pkg::addr_t'(`MC_DMEM_WORDS - 1);

  mc_pkg::tag_state_e state_r;
  mc_pkg::addr_t      clear_addr_r;
  logic [`MC_RESET_DEPTH-1:0] done_chain_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r      <= mc_pkg::TAG_CLEAR;
      clear_addr_r <= '0;
      done_chain_r <= '0;
    end else begin
      // done flag ages through the chain
      done_chain_r <= {done_chain_r[`MC_RESET_DEPTH-2:0], state_r != mc_pkg::TAG_CLEAR};
      case (state_r)
        mc_pkg::TAG_CLEAR: begin
          clear_addr_r <= clear_addr_r + 1'b1;
          if (clear_addr_r == last_addr_lp) begin
            state_r <= mc_pkg::TAG_HOLD;
          end
        end
        mc_pkg::TAG_HOLD: begin
          if (done_chain_r[`MC_RESET_DEPTH-1]) begin
            state_r <= mc_pkg::TAG_RUN;
          end
        end
        default: begin
          state_r <= mc_pkg::TAG_RUN; // stays until rst_i
        end
      endcase
    end
  end

  assign clear_v_o    = (state_r == mc_pkg::TAG_CLEAR);
  assign clear_addr_o = clear_addr_r;
  assign core_rst_o   = ~done_chain_r[`MC_RESET_DEPTH-1];

  // cores must stay in reset while memories are swept
  a_clear_in_reset: assert property (@(posedge clk_i) clear_v_o |-> core_rst_o)
    else $error("clear_v_o high with core reset released");

endmodule

// ==== source/mc_pkg.sv ====
`include "mc_consts.svh"

package mc_pkg;

  typedef logic [`MC_X_CORD_WIDTH-1:0] x_cord_t;
  typedef logic [`MC_Y_CORD_WIDTH-1:0] y_cord_t;
  typedef logic [`MC_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`MC_DATA_WIDTH-1:0]   data_t;

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mc_op_e;

  typedef enum logic {
    RET_LOAD = 1'b0,
    RET_STAT = 1'b1
  } mc_ret_e;

  typedef enum logic [1:0] {
    TAG_CLEAR = 2'd0,
    TAG_HOLD  = 2'd1,
    TAG_RUN   = 2'd2
  } tag_state_e;

  // host to tile
  typedef struct packed {
    logic    v;
    mc_op_e  op;
    x_cord_t x;
    y_cord_t y;
    addr_t   addr;
    data_t   data;
  } mc_req_s;

  // tile to host
  typedef struct packed {
    logic    v;
    mc_ret_e kind;
    data_t   data;
  } mc_ret_s;

endpackage

// ==== include/mc_consts.svh ====
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

// array size
`define MC_TILES_X 2
`define MC_TILES_Y 2

`define MC_X_CORD_WIDTH 1
`define MC_Y_CORD_WIDTH 1

// word addressed
`define MC_ADDR_WIDTH 8
`define MC_DATA_WIDTH 32

`define MC_DMEM_WORDS 256

// stores here go back to the host, never to memory
`define MC_PRINT_STAT_ADDR 255

// core reset release delay after tag programming
`define MC_RESET_DEPTH 3

`endif
